//--- logic/matrix_pkg.sv
package matrix_pkg;

    // Digit on the display
    typedef logic [2:0] digit_t;

    // Index of the scanned row
    typedef logic [2:0] row_idx_t;

    // Row select or one colour plane
    typedef logic [7:0] line_t;

    localparam int unsigned NUM_ROWS = 8;
    localparam digit_t START_DIGIT = 3'd7;

    typedef enum logic [1:0]
    {
        IDLE,
        COUNT,
        DONE
    } cd_state_t;

endpackage

//--- logic/glyph_if.sv
interface glyph_if
    import matrix_pkg::*;
();

    digit_t   digit;
    row_idx_t row_idx;
    line_t    red;
    line_t    green;

    // Scanner side
    modport lookup (
        output digit,
        output row_idx,
        input  red,
        input  green
    );

    // Answered in the same cycle
    modport tbl (
        input  digit,
        input  row_idx,
        output red,
        output green
    );

endinterface

//--- logic/tick_gen.sv
module tick_gen #(
    parameter int unsigned SCAN_DIV = 4,
    parameter int unsigned SEC_DIV  = 128
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic sec_tick
);

    localparam int unsigned CW = $clog2(SEC_DIV);

    logic [CW-1:0] cnt;
    logic          cnt_wrap;
    logic          scan_hit;

    assign cnt_wrap = (cnt == CW'(SEC_DIV - 1));

    // Last cycle of each scan slot
    assign scan_hit = ((cnt % CW'(SCAN_DIV)) == CW'(SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= '0;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
        else
        begin
            if (cnt_wrap)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
            scan_tick <= scan_hit;
            sec_tick  <= cnt_wrap;  // Always lands with a scan tick
        end
    end

endmodule

//--- logic/countdown_ctrl.sv
module countdown_ctrl
    import matrix_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   st,
    input  logic   sec_tick,
    output digit_t digit,
    output logic   show,
    output logic   done
);

    cd_state_t state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            digit <= START_DIGIT;
        end
        else if (!st)
        begin
            // Blank and reload in any state
            state <= IDLE;
            digit <= START_DIGIT;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    state <= COUNT;
                    digit <= START_DIGIT;
                end
                COUNT:
                begin
                    if (sec_tick)
                    begin
                        if (digit == '0)
                            state <= DONE;  // 0 has had its full second
                        else
                            digit <= digit - 1'b1;
                    end
                end
                DONE:
                    digit <= '0;
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign show = (state == COUNT) || (state == DONE);
    assign done = (state == DONE);

endmodule

//--- logic/glyph_rom.sv
module glyph_rom
    import matrix_pkg::*;
(
    glyph_if.tbl g
);

    line_t pat;
    logic  red_on;
    logic  green_on;

    // Shape of each digit with one byte per row
    always_comb
    begin
        pat = '0;
        case (g.digit)
            3'd7:
                case (g.row_idx)
                    3'd1:    pat = 8'b0010_0010;
                    3'd2:    pat = 8'b0111_0111;
                    3'd3:    pat = 8'b1111_1111;
                    3'd4:    pat = 8'b0111_1111;
                    3'd5:    pat = 8'b0011_1110;
                    3'd6:    pat = 8'b0001_1100;
                    default: pat = '0;
                endcase
            3'd6:
                case (g.row_idx)
                    3'd0:    pat = 8'b0111_1000;
                    3'd1:    pat = 8'b1100_1100;
                    3'd2:    pat = 8'b0000_1100;
                    3'd3:    pat = 8'b0001_1000;
                    3'd4:    pat = 8'b0011_0000;
                    3'd6:    pat = 8'b0011_0000;
                    default: pat = '0;
                endcase
            3'd5:
                case (g.row_idx)
                    3'd1:       pat = 8'b0111_1110;
                    3'd2:       pat = 8'b0110_0000;
                    3'd3:       pat = 8'b0111_1100;
                    3'd4, 3'd5: pat = 8'b0000_0110;
                    3'd6:       pat = 8'b0110_0110;
                    3'd7:       pat = 8'b0011_1100;
                    default:    pat = '0;
                endcase
            3'd4:
                case (g.row_idx)
                    3'd1, 3'd6, 3'd7: pat = 8'b0000_1100;
                    3'd2:             pat = 8'b0001_1100;
                    3'd3:             pat = 8'b0010_1100;
                    3'd4:             pat = 8'b0100_1100;
                    3'd5:             pat = 8'b0111_1110;
                    default:          pat = '0;
                endcase
            3'd3:
                case (g.row_idx)
                    3'd1, 3'd7: pat = 8'b0011_1100;
                    3'd2, 3'd6: pat = 8'b0110_0110;
                    3'd3, 3'd5: pat = 8'b0000_0110;
                    3'd4:       pat = 8'b0001_1100;
                    default:    pat = '0;
                endcase
            3'd2:
                case (g.row_idx)
                    3'd1:    pat = 8'b0011_1100;
                    3'd2:    pat = 8'b0110_0110;
                    3'd3:    pat = 8'b0000_0110;
                    3'd4:    pat = 8'b0000_1100;
                    3'd5:    pat = 8'b0011_0000;
                    3'd6:    pat = 8'b0110_0000;
                    3'd7:    pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            3'd1:
                case (g.row_idx)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: pat = 8'b0001_1000;
                    3'd3:                         pat = 8'b0011_1000;
                    3'd7:                         pat = 8'b0111_1110;
                    default:                      pat = '0;
                endcase
            default:
                case (g.row_idx)
                    3'd1, 3'd7:                   pat = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: pat = 8'b0100_0010;
                    default:                      pat = '0;
                endcase
        endcase
    end

    // Colour of each digit
    always_comb
    begin
        case (g.digit)
            3'd6, 3'd5, 3'd4: {red_on, green_on} = 2'b10;
            3'd1, 3'd0:       {red_on, green_on} = 2'b01;
            default:          {red_on, green_on} = 2'b11;
        endcase
    end

    assign g.red   = red_on ? pat : '0;
    assign g.green = green_on ? pat : '0;

endmodule

//--- logic/matrix_scan.sv
module matrix_scan
    import matrix_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   scan_tick,
    input  digit_t digit,
    input  logic   show,
    glyph_if.lookup g,
    output line_t  row,
    output line_t  colr,
    output line_t  colg
);

    row_idx_t row_cnt;

    // Glyph lookup for the row about to be driven
    assign g.digit   = digit;
    assign g.row_idx = row_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row     <= '1;
            colr    <= '0;
            colg    <= '0;
            row_cnt <= '0;
        end
        else if (!show)
        begin
            row     <= '1;  // All rows off
            colr    <= '0;
            colg    <= '0;
            row_cnt <= '0;
        end
        else if (scan_tick)
        begin
            row  <= ~(line_t'(1) << row_cnt);  // Active low
            colr <= g.red;
            colg <= g.green;
            if (row_cnt == row_idx_t'(NUM_ROWS - 1))
                row_cnt <= '0;
            else
                row_cnt <= row_cnt + 1'b1;
        end
    end

endmodule

//--- logic/matrix_countdown_top.sv
module matrix_countdown_top
    import matrix_pkg::*;
#(
    parameter int unsigned SCAN_DIV = 4,
    parameter int unsigned SEC_DIV  = 128  // Multiple of SCAN_DIV * NUM_ROWS
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  st,
    output line_t row,
    output line_t colr,
    output line_t colg,
    output logic  done
);

    logic   scan_tick;
    logic   sec_tick;
    digit_t digit;
    logic   show;

    glyph_if g_if ();

    tick_gen #(
        .SCAN_DIV (SCAN_DIV),
        .SEC_DIV  (SEC_DIV)
    ) u_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    countdown_ctrl u_countdown_ctrl (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .sec_tick (sec_tick),
        .digit    (digit),
        .show     (show),
        .done     (done)
    );

    matrix_scan u_matrix_scan (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digit     (digit),
        .show      (show),
        .g         (g_if.lookup),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

    glyph_rom u_glyph_rom (
        .g (g_if.tbl)
    );

endmodule

//--- tb/tb_matrix_countdown.sv
module tb_matrix_countdown
    import matrix_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SCAN_DIV = 4;
    localparam int unsigned SEC_DIV  = 128;

    localparam int GAP_MIN = 8;
    localparam int ON_FULL = 8 * SEC_DIV + 64;  // Full countdown and some of the done phase
    localparam int ON_PART = 2 * SEC_DIV;
    localparam int MAX_CYCLES = 16 + 4 * (GAP_MIN + 31 + 2) + 3 * (ON_FULL + 63)
                              + (ON_PART + 255) + 200;

    logic  clk = 1'b0;
    logic  rst;
    logic  st;
    line_t row;
    line_t colr;
    line_t colg;
    logic  done;

    int   seed;
    int   cycles = 0;
    int   sec_phase = 0;
    logic active = 1'b0;
    logic blank_chk = 1'b1;

    // Monitor state
    logic  was_active = 1'b0;
    line_t prev_row = '1;
    line_t exp_row;
    line_t frame_or;
    int    win;
    int    win_changes;
    int    n_changes;
    int    since_change = 0;

    always #4 clk = ~clk;

    matrix_countdown_top #(
        .SCAN_DIV (SCAN_DIV),
        .SEC_DIV  (SEC_DIV)
    ) u_matrix_countdown_top (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .row  (row),
        .colr (colr),
        .colg (colg),
        .done (done)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0d ns %s: expected %0h, got %0h", $time, name, expected, actual);
        $display("Checks failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic stop_with_reason(input string why);
        $display("[ERROR] %0d ns %s", $time, why);
        $display("Checks failed");
        $fatal(1, "Run stopped");
    endtask

    // Off gap then st high for on_cycles before it drops
    task automatic run_countdown(input int on_cycles);
        int gap;
        gap = GAP_MIN + ($random(seed) & 31);
        repeat (gap) @(posedge clk);
        st <= 1'b1;
        blank_chk = 1'b0;
        active = 1'b1;
        repeat (on_cycles) @(posedge clk);
        st <= 1'b0;
        active = 1'b0;
        repeat (2) @(posedge clk);
        blank_chk = 1'b1;  // Blank within two cycles
    endtask

    // Second boundaries counted from reset release
    always @(posedge clk)
    begin
        if (rst)
            sec_phase <= 0;
        else if (sec_phase == SEC_DIV - 1)
            sec_phase <= 0;
        else
            sec_phase <= sec_phase + 1;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_with_reason($sformatf("Timeout: run did not end within %0d cycles", cycles));
    end

    always @(negedge clk)
    begin
        since_change = since_change + 1;
        if (blank_chk)
        begin
            assert (row == '1) else report_mismatch("row", 8'hff, row);
            assert (colr == '0) else report_mismatch("colr", 0, colr);
            assert (colg == '0) else report_mismatch("colg", 0, colg);
            assert (done == 1'b0) else report_mismatch("done", 0, done);
        end
        if (active && !was_active)
        begin
            win = 0;
            win_changes = 0;
            n_changes = 0;
            frame_or = '0;
        end
        was_active = active;
        if (active && row != prev_row)
        begin
            // Zero walks up one bit per scan tick from row 0
            exp_row = (n_changes == 0) ? 8'hfe : {prev_row[6:0], prev_row[7]};
            assert (row == exp_row) else report_mismatch("row", exp_row, row);
            if (n_changes != 0)
                assert (since_change == SCAN_DIV)
                    else report_mismatch("row change interval", SCAN_DIV, since_change);
            case (win)
                0, 4, 5: assert (colg == colr) else report_mismatch("colg", colr, colg);
                1, 2, 3: assert (colg == '0) else report_mismatch("colg", 0, colg);
                default: assert (colr == '0) else report_mismatch("colr", 0, colr);
            endcase
            if (win >= 8)
            begin
                assert (done == 1'b1) else report_mismatch("done", 1, done);
            end
            else if (win < 7 || sec_phase != 1)
            begin
                assert (done == 1'b0) else report_mismatch("done", 0, done);
            end
            frame_or = frame_or | colr | colg;
            win_changes = win_changes + 1;
            n_changes = n_changes + 1;
            since_change = 0;
            if (sec_phase == 1)  // Last row registered before the digit steps
            begin
                if (win_changes >= NUM_ROWS)
                    assert (frame_or != '0)
                        else stop_with_reason($sformatf("Window %0d showed a blank frame", win));
                win = win + 1;
                win_changes = 0;
                frame_or = '0;
            end
        end
        prev_row = row;
    end

    initial
    begin
        seed = 27017;
        rst = 1'b1;
        st = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        run_countdown(ON_FULL + ($random(seed) & 63));
        run_countdown(ON_PART + ($random(seed) & 255));  // Dropped mid count
        run_countdown(ON_FULL + ($random(seed) & 63));
        run_countdown(ON_FULL + ($random(seed) & 63));
        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- vlog.f
logic/matrix_pkg.sv
logic/glyph_if.sv
logic/tick_gen.sv
logic/countdown_ctrl.sv
logic/glyph_rom.sv
logic/matrix_scan.sv
logic/matrix_countdown_top.sv
tb/tb_matrix_countdown.sv

//--- Makefile
SIM        = verilator
FILELIST   = vlog.f
TOP        = tb_matrix_countdown
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
